// File: common/port_params.svh
`ifndef PORT_PARAMS_SVH
`define PORT_PARAMS_SVH

// number of clients sharing the port.
`define SP_NUM_CLIENTS 4

// downstream port address width.
`define SP_ADDR_WIDTH 16

// a length field of n means n+1 beats.
`define SP_LEN_WIDTH 4

`endif

// File: common/port_pkg.sv
`include "port_params.svh"

package port_pkg;

    // one bit per client, for requests, grants and acks.
    typedef logic [`SP_NUM_CLIENTS-1:0] client_vec_t;

    typedef logic [$clog2(`SP_NUM_CLIENTS)-1:0] client_idx_t;

    typedef logic [`SP_ADDR_WIDTH-1:0] addr_t;

    // a length field or the remaining beats minus one.
    typedef logic [`SP_LEN_WIDTH-1:0] beat_len_t;

    typedef enum logic {
        PS_IDLE = 1'b0,
        PS_BUSY = 1'b1
    } port_state_t;

endpackage

// File: arbiter/onehot_encoder.sv
`timescale 1ns/1ps

module onehot_encoder #(
    parameter int num_reqs = 4
) (
    input  port_pkg::client_vec_t onehot,
    output port_pkg::client_idx_t binary
);

    // each index bit is the OR of the one-hot bits whose position has it set.
    always_comb begin
        binary = '0;
        for (int i = 0; i < num_reqs; i++) begin
            if (onehot[i]) begin
                binary = binary | port_pkg::client_idx_t'(i);
            end
        end
    end

endmodule

// File: arbiter/matrix_arbiter.sv
`timescale 1ns/1ps

module matrix_arbiter #(
    parameter int num_reqs    = 4,
    parameter bit lock_enable = 1'b1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  port_pkg::client_vec_t requests,
    output port_pkg::client_idx_t grant_index,
    output port_pkg::client_vec_t grant_onehot,
    output logic                  grant_valid
);

    if (num_reqs == 1) begin : g_single

        // a lone requester always wins.
        assign grant_index  = '0;
        assign grant_onehot = port_pkg::client_vec_t'(requests[0]);
        assign grant_valid  = requests[0];

    end else begin : g_matrix

        // prio[i][j] with i < j is set when client i beats client j.
        logic [num_reqs-1:0]   prio [num_reqs];
        port_pkg::client_vec_t grant_unqual;

        always_comb begin
            logic blocked;
            grant_unqual = '0;
            for (int j = 0; j < num_reqs; j++) begin
                blocked = 1'b0;
                for (int i = 0; i < num_reqs; i++) begin
                    if (i < j) begin
                        blocked = blocked | (requests[i] & prio[i][j]);
                    end else if (i > j) begin
                        blocked = blocked | (requests[i] & ~prio[j][i]);
                    end
                end
                grant_unqual[j] = requests[j] & ~blocked;
            end
        end

        // the accepted winner drops below every other client.
        // out of reset lower numbers come first.
        always_ff @(posedge clk) begin
            for (int i = 0; i < num_reqs; i++) begin
                for (int j = i + 1; j < num_reqs; j++) begin
                    if (reset) begin
                        prio[i][j] <= 1'b1;
                    end else if (enable && grant_unqual[i]) begin
                        prio[i][j] <= 1'b0;
                    end else if (enable && grant_unqual[j]) begin
                        prio[i][j] <= 1'b1;
                    end
                end
            end
        end

        if (lock_enable) begin : g_lock
            port_pkg::client_vec_t grant_prev;

            always_ff @(posedge clk) begin
                if (reset) begin
                    grant_prev <= '0;
                end else if (enable) begin
                    grant_prev <= grant_unqual;
                end
            end

            // hold the owner while its burst runs.
            assign grant_onehot = enable ? grant_unqual : grant_prev;
        end else begin : g_nolock
            assign grant_onehot = grant_unqual;
        end

        onehot_encoder #(
            .num_reqs (num_reqs)
        ) encoder (
            .onehot (grant_unqual),
            .binary (grant_index)
        );

        assign grant_valid = |requests;

    end

endmodule

// File: design/beat_timer.sv
`timescale 1ns/1ps

module beat_timer (
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  port_pkg::beat_len_t load_len,
    input  logic                advance,
    output logic                last
);

    // beats remaining minus one.
    port_pkg::beat_len_t count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= load_len;
        end else if (advance && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign last = (count == '0);

endmodule

// File: design/burst_datapath.sv
`timescale 1ns/1ps

`include "port_params.svh"

module burst_datapath (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      load,
    input  port_pkg::client_idx_t                     sel,
    input  port_pkg::addr_t     [`SP_NUM_CLIENTS-1:0] req_addr,
    input  port_pkg::beat_len_t [`SP_NUM_CLIENTS-1:0] req_len,
    input  logic                                      advance,
    output port_pkg::beat_len_t                       beat_len,
    output port_pkg::client_idx_t                     owner,
    output port_pkg::addr_t                           beat_addr
);

    always_ff @(posedge clk) begin
        if (reset) begin
            owner     <= '0;
            beat_addr <= '0;
        end else if (load) begin
            owner     <= sel;
            beat_addr <= req_addr[sel];
        end else if (advance) begin
            beat_addr <= beat_addr + 1'b1;
        end
    end

    // the timer only samples the length in the grab cycle.
    assign beat_len = req_len[sel];

endmodule

// File: design/port_controller.sv
`timescale 1ns/1ps

module port_controller (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  grant_valid,
    input  port_pkg::client_vec_t grant_onehot,
    input  logic                  port_ready,
    input  logic                  last,
    output logic                  grab,
    output logic                  advance,
    output logic                  busy,
    output port_pkg::client_vec_t ack
);

    port_pkg::port_state_t state;
    port_pkg::port_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            port_pkg::PS_IDLE: begin
                if (grant_valid) begin
                    state_next = port_pkg::PS_BUSY;
                end
            end
            port_pkg::PS_BUSY: begin
                if (port_ready && last) begin
                    state_next = port_pkg::PS_IDLE;
                end
            end
            default: state_next = port_pkg::PS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= port_pkg::PS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign busy    = (state == port_pkg::PS_BUSY);
    assign grab    = (state == port_pkg::PS_IDLE) && grant_valid;
    assign advance = busy && port_ready;

    // ack the locked owner on its final accepted beat.
    assign ack = (advance && last) ? grant_onehot : '0;

endmodule

// File: design/shared_port.sv
`timescale 1ns/1ps

`include "port_params.svh"

module shared_port (
    input  logic                                      clk,
    input  logic                                      reset,
    input  port_pkg::client_vec_t                     req,
    input  port_pkg::addr_t     [`SP_NUM_CLIENTS-1:0] req_addr,
    input  port_pkg::beat_len_t [`SP_NUM_CLIENTS-1:0] req_len,
    input  logic                                      port_ready,
    output port_pkg::client_vec_t                     ack,
    output logic                                      port_valid,
    output port_pkg::addr_t                           port_addr,
    output logic                                      port_last,
    output port_pkg::client_idx_t                     port_owner
);

    port_pkg::client_vec_t grant_onehot;
    port_pkg::client_idx_t grant_index;
    logic                  grant_valid;
    logic                  grab;
    logic                  advance;
    logic                  busy;
    logic                  last;
    port_pkg::beat_len_t   beat_len;

    matrix_arbiter #(
        .num_reqs    (`SP_NUM_CLIENTS),
        .lock_enable (1'b1)
    ) arbiter (
        .clk          (clk),
        .reset        (reset),
        .enable       (grab),
        .requests     (req),
        .grant_index  (grant_index),
        .grant_onehot (grant_onehot),
        .grant_valid  (grant_valid)
    );

    port_controller controller (
        .clk          (clk),
        .reset        (reset),
        .grant_valid  (grant_valid),
        .grant_onehot (grant_onehot),
        .port_ready   (port_ready),
        .last         (last),
        .grab         (grab),
        .advance      (advance),
        .busy         (busy),
        .ack          (ack)
    );

    beat_timer timer (
        .clk      (clk),
        .reset    (reset),
        .load     (grab),
        .load_len (beat_len),
        .advance  (advance),
        .last     (last)
    );

    burst_datapath datapath (
        .clk       (clk),
        .reset     (reset),
        .load      (grab),
        .sel       (grant_index),
        .req_addr  (req_addr),
        .req_len   (req_len),
        .advance   (advance),
        .beat_len  (beat_len),
        .owner     (port_owner),
        .beat_addr (port_addr)
    );

    assign port_valid = busy;
    assign port_last  = busy && last;

endmodule

// File: bench/shared_port_tb.sv
`timescale 1ns/1ps

`include "port_params.svh"

module shared_port_tb;

    localparam int NUM_TESTS = 7;
    localparam int NC = `SP_NUM_CLIENTS;

    logic                                      clk;
    logic                                      reset;
    port_pkg::client_vec_t                     req;
    port_pkg::addr_t     [`SP_NUM_CLIENTS-1:0] req_addr;
    port_pkg::beat_len_t [`SP_NUM_CLIENTS-1:0] req_len;
    logic                                      port_ready;
    port_pkg::client_vec_t                     ack;
    logic                                      port_valid;
    port_pkg::addr_t                           port_addr;
    logic                                      port_last;
    port_pkg::client_idx_t                     port_owner;

    // stimulus table and the owner of each test's first burst.
    string                                     test_name   [NUM_TESTS];
    logic                                      test_reset  [NUM_TESTS];
    port_pkg::client_vec_t                     test_mask   [NUM_TESTS];
    port_pkg::client_vec_t                     test_late   [NUM_TESTS];
    port_pkg::addr_t     [`SP_NUM_CLIENTS-1:0] test_addr   [NUM_TESTS];
    port_pkg::beat_len_t [`SP_NUM_CLIENTS-1:0] test_len    [NUM_TESTS];
    logic                                      test_random [NUM_TESTS];
    int                                        test_first  [NUM_TESTS];

    // least recently granted client first.
    int          lrg_order [NC];
    logic [31:0] lfsr_state;
    string       cur_name;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          failed_tests;
    int          watchdog_cycles;

    shared_port UUT (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_addr   (req_addr),
        .req_len    (req_len),
        .port_ready (port_ready),
        .ack        (ack),
        .port_valid (port_valid),
        .port_addr  (port_addr),
        .port_last  (port_last),
        .port_owner (port_owner)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic set_row(input int idx, input string name, input logic rst,
                           input port_pkg::client_vec_t mask, input port_pkg::client_vec_t late,
                           input port_pkg::addr_t [NC-1:0] addrs,
                           input port_pkg::beat_len_t [NC-1:0] lens,
                           input logic rnd, input int first);
        test_name[idx]   = name;
        test_reset[idx]  = rst;
        test_mask[idx]   = mask;
        test_late[idx]   = late;
        test_addr[idx]   = addrs;
        test_len[idx]    = lens;
        test_random[idx] = rnd;
        test_first[idx]  = first;
    endtask

    // length nibble i belongs to client i.
    task automatic load_table();
        set_row(0, "lone_client2", 1'b0, 4'b0100, 4'b0000,
                {16'h4000, 16'h3000, 16'h2a10, 16'h1000}, 16'h0300, 1'b0, 2);
        set_row(1, "all_four_reset", 1'b1, 4'b1111, 4'b0000,
                {16'h0c00, 16'h0800, 16'h0400, 16'h0000}, 16'h3021, 1'b0, 0);
        set_row(2, "partial_round", 1'b0, 4'b0110, 4'b0000,
                {16'h7000, 16'h6100, 16'h5200, 16'h4300}, 16'h0120, 1'b0, 1);
        set_row(3, "repeat_round", 1'b0, 4'b1111, 4'b0000,
                {16'hff00, 16'h00f0, 16'h1234, 16'hbeef}, 16'h1102, 1'b0, 0);
        set_row(4, "late_request", 1'b0, 4'b0100, 4'b1001,
                {16'h9000, 16'h8800, 16'h8000, 16'h7800}, 16'h2503, 1'b0, 2);
        set_row(5, "random_ready", 1'b0, 4'b1111, 4'b0000,
                {16'hc000, 16'hb000, 16'ha000, 16'h2fff}, 16'hf173, 1'b1, 1);
        set_row(6, "random_late", 1'b0, 4'b0010, 4'b1100,
                {16'he400, 16'he000, 16'hd800, 16'hd000}, 16'h4260, 1'b1, 1);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        req = '0;
        port_ready = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NC; i++) begin
            lrg_order[i] = i;
        end
    endtask

    // the winner moves to the back of the order.
    task automatic take_winner(input port_pkg::client_vec_t pend, output int winner);
        int pos;
        pos = 0;
        for (int i = NC - 1; i >= 0; i--) begin
            if (pend[lrg_order[i]]) begin
                pos = i;
            end
        end
        winner = lrg_order[pos];
        for (int i = pos; i < NC - 1; i++) begin
            lrg_order[i] = lrg_order[i + 1];
        end
        lrg_order[NC - 1] = winner;
    endtask

    task automatic report_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", cur_name);
        end else begin
            $display("test %s: %0d errors", cur_name, test_errors);
            failed_tests++;
        end
    endtask

    task automatic check_idle(input int cycles);
        cur_name = "idle_after_reset";
        test_errors = 0;
        repeat (cycles) begin
            @(negedge clk);
            req = '0;
            port_ready = 1'b1;
            #1;
            check_value("port_valid", 0, port_valid);
            check_value("ack", 0, ack);
        end
        report_test();
    endtask

    task automatic run_test(input int t);
        port_pkg::client_vec_t pending;
        port_pkg::client_vec_t late_left;
        port_pkg::client_vec_t exp_ack;
        port_pkg::addr_t       exp_addr;
        port_pkg::beat_len_t   len;
        int                    owner;
        int                    beat;
        int                    cycle;
        int                    bursts;
        int                    first_cycle;
        int                    ack_cycle;
        int                    beats_done;
        int                    exp_beats;
        logic                  active;
        cur_name = test_name[t];
        test_errors = 0;
        if (test_reset[t]) begin
            apply_reset();
        end
        pending = test_mask[t];
        late_left = test_late[t];
        exp_beats = 0;
        for (int i = 0; i < NC; i++) begin
            if (pending[i] || late_left[i]) begin
                exp_beats += test_len[t][i] + 1;
            end
        end
        active = 1'b0;
        owner = 0;
        beat = 0;
        len = '0;
        exp_addr = '0;
        cycle = 0;
        bursts = 0;
        first_cycle = 0;
        ack_cycle = 0;
        beats_done = 0;
        while (pending != '0) begin
            @(negedge clk);
            req_addr = test_addr[t];
            req_len = test_len[t];
            req = pending;
            if (test_random[t]) begin
                lfsr_state = lfsr_step(lfsr_state);
                port_ready = lfsr_state[0];
            end else begin
                port_ready = 1'b1;
            end
            #1;
            if (port_valid && !active) begin
                take_winner(pending, owner);
                if (bursts == 0) begin
                    check_value("first owner", test_first[t], port_owner);
                    check_value("first beat cycle", 1, cycle);
                end else begin
                    check_value("ack to next beat", 2, cycle - ack_cycle);
                end
                active = 1'b1;
                beat = 0;
                len = test_len[t][owner];
                first_cycle = cycle;
                exp_addr = test_addr[t][owner];
                bursts++;
                // late clients raise their request while this burst runs.
                pending = pending | late_left;
                late_left = '0;
            end
            if (active) begin
                exp_ack = (port_ready && beat == len) ? port_pkg::client_vec_t'(1 << owner) : '0;
                check_value("port_valid", 1, port_valid);
                check_value("port_owner", owner, port_owner);
                check_value("port_addr", exp_addr, port_addr);
                check_value("port_last", beat == len, port_last);
                check_value("ack", exp_ack, ack);
                if (ack != '0 && !test_random[t]) begin
                    check_value("ack delay", len, cycle - first_cycle);
                end
                if (port_ready) begin
                    if (beat == len) begin
                        pending[owner] = 1'b0;
                        active = 1'b0;
                        ack_cycle = cycle;
                    end else begin
                        beat++;
                        exp_addr = exp_addr + 1'b1;
                    end
                end
            end else begin
                check_value("port_last idle", 0, port_last);
                check_value("ack idle", 0, ack);
            end
            if (port_valid && port_ready) begin
                beats_done++;
            end
            cycle++;
        end
        check_value("beat count", exp_beats, beats_done);
        report_test();
    endtask

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the bursts did not complete within %0d cycles", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int total_beats;
        reset = 1'b1;
        req = '0;
        req_addr = '0;
        req_len = '0;
        port_ready = 1'b0;
        errors = 0;
        tests_run = 0;
        failed_tests = 0;
        lfsr_state = 32'h4f4b1e6c;
        load_table();
        total_beats = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < NC; i++) begin
                if (test_mask[t][i] || test_late[t][i]) begin
                    total_beats += test_len[t][i] + 1;
                end
            end
        end
        watchdog_cycles = total_beats * 8 + NUM_TESTS * 16 + 100;
        apply_reset();
        check_idle(6);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        @(negedge clk);
        req = '0;
        $display("%0d tests run, %0d failed, %0d errors", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: shared_port.f
+incdir+common
common/port_pkg.sv
arbiter/onehot_encoder.sv
arbiter/matrix_arbiter.sv
design/beat_timer.sv
design/burst_datapath.sv
design/port_controller.sv
design/shared_port.sv
bench/shared_port_tb.sv

// File: Bender.yml
package:
  name: shared_port

sources:
  - include_dirs:
      - common
    files:
      - common/port_pkg.sv
      - arbiter/onehot_encoder.sv
      - arbiter/matrix_arbiter.sv
      - design/beat_timer.sv
      - design/burst_datapath.sv
      - design/port_controller.sv
      - design/shared_port.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/shared_port_tb.sv
